// File: logic/div_defs.svh
`ifndef DIV_DEFS_SVH
`define DIV_DEFS_SVH

// operand widths
`define DIV_DIVIDEND_W  16
`define DIV_DIVISOR_W   8   // divisor, quotient and remainder

// one subtract row per quotient bit
`define DIV_ROWS        8

// low columns of each row built from approximate cells, 0 keeps every row exact
`define DIV_APPROX_COLS 0

`endif

// File: logic/div_data_pkg.sv
package div_data_pkg;

`include "div_defs.svh"

    // operands at the divider boundary
    typedef logic [`DIV_DIVIDEND_W-1:0] dividend_t;
    typedef logic [`DIV_DIVISOR_W-1:0]  divisor_t;

    // results
    typedef logic [`DIV_DIVISOR_W-1:0]  quotient_t;
    typedef logic [`DIV_DIVISOR_W-1:0]  remainder_t;

endpackage

// File: logic/div_pipe_pkg.sv
package div_pipe_pkg;

`include "div_defs.svh"

    // previous remainder with the next dividend bit below it
    typedef logic [`DIV_DIVISOR_W:0]   partial_t;

    // dividend bits still to come, msb is the next one in
    typedef logic [`DIV_DIVISOR_W-1:0] pending_t;

    // quotient bits so far, shifted in at the lsb
    typedef logic [`DIV_ROWS-1:0]      qacc_t;

endpackage

// File: logic/row_if.sv
interface row_if import div_data_pkg::*, div_pipe_pkg::*; ();

    partial_t partial;
    pending_t pending;
    divisor_t divisor;  // travels with its dividend through every row
    qacc_t    qacc;

    // registered side of a row
    modport src (
        output partial,
        output pending,
        output divisor,
        output qacc
    );

    // consuming row
    modport dst (
        input  partial,
        input  pending,
        input  divisor,
        input  qacc
    );

endinterface

// File: logic/sub_row.sv
module sub_row import div_data_pkg::*, div_pipe_pkg::*; #(
    parameter int approx_cols = 0
) (
    input  partial_t   partial,
    input  divisor_t   divisor,
    output logic       qbit,
    output remainder_t rem
);

    localparam int cols = $bits(divisor_t);

    logic [cols:0]   borrow;    // borrow[c] enters column c
    logic [cols-1:0] differ;    // x and y differ per column
    logic [cols-1:0] diff;

    // a divider row never takes a borrow in
    assign borrow[0] = 1'b0;

    for (genvar c = 0; c < cols; c++) begin : g_col
        assign differ[c] = partial[c] ^ divisor[c];

        // same borrow rule in both cell kinds
        assign borrow[c+1] = differ[c] ? divisor[c] : borrow[c];

        if (c < approx_cols) begin : g_apx
            assign diff[c] = borrow[c+1];  // approximation 3, difference follows borrow-out
        end else begin : g_exact
            assign diff[c] = differ[c] ^ borrow[c];
        end
    end

    // subtract succeeds when the top bit covers the borrow
    assign qbit = partial[cols] | ~borrow[cols];

    // restore the partial remainder on a failed subtract
    always_comb begin
        if (qbit) begin
            rem = remainder_t'(diff);
        end else begin
            rem = remainder_t'(partial[cols-1:0]);
        end
    end

endmodule

// File: logic/div_stage.sv
module div_stage import div_data_pkg::*, div_pipe_pkg::*; #(
    parameter int approx_cols = 0
) (
    input  logic clk,
    input  logic rst_n,
    row_if.dst   up,
    row_if.src   down
);

    localparam int qacc_w    = $bits(qacc_t);
    localparam int pending_w = $bits(pending_t);

    logic       qbit;
    remainder_t rem;

    sub_row #(
        .approx_cols (approx_cols)
    ) u_row (
        .partial (up.partial),
        .divisor (up.divisor),
        .qbit    (qbit),
        .rem     (rem)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            down.partial <= '0;
            down.pending <= '0;
            down.divisor <= '0;
            down.qacc    <= '0;
        end else begin
            down.divisor <= up.divisor;
            down.qacc    <= {up.qacc[qacc_w-2:0], qbit};  // newest quotient bit at the lsb
            // bring down the next dividend bit under the remainder
            down.partial <= {rem, up.pending[pending_w-1]};
            down.pending <= up.pending << 1;
        end
    end

    // row state is clean one cycle after a reset edge
    a_reset_clear: assert property (
        @(posedge clk) !rst_n |=> (down.partial == '0 && down.pending == '0 &&
                                   down.divisor == '0 && down.qacc == '0)
    ) else $error("div_stage: row registers not cleared after reset");

    // divisor moves down one row per cycle, unchanged
    a_divisor_follow: assert property (
        @(posedge clk) rst_n |=> (down.divisor == $past(up.divisor))
    ) else $error("div_stage: divisor lost between rows");

endmodule

// File: logic/array_div.sv
`include "div_defs.svh"

module array_div import div_data_pkg::*; #(
    parameter int approx_cols = `DIV_APPROX_COLS
) (
    input  logic       clk,
    input  logic       rst_n,
    input  dividend_t  dividend,
    input  divisor_t   divisor,
    output quotient_t  quotient,
    output remainder_t remainder
);

    // dividend bits that start in the first partial, the rest drain from pending
    localparam int top_w  = `DIV_DIVISOR_W + 1;
    localparam int low_w  = `DIV_DIVIDEND_W - top_w;

    dividend_t in_dividend;
    divisor_t  in_divisor;

    // rows[0] comes from the input registers, rows[i+1] from stage i
    row_if rows [0:`DIV_ROWS] ();

    // operand capture, one pair per clock
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_dividend <= '0;
            in_divisor  <= '0;
        end else begin
            in_dividend <= dividend;
            in_divisor  <= divisor;
        end
    end

    assign rows[0].partial = in_dividend[`DIV_DIVIDEND_W-1 -: top_w];
    assign rows[0].pending = {in_dividend[low_w-1:0], 1'b0};  // left-aligned
    assign rows[0].divisor = in_divisor;
    assign rows[0].qacc    = '0;

    for (genvar i = 0; i < `DIV_ROWS; i++) begin : g_row
        div_stage #(
            .approx_cols (approx_cols)
        ) u_stage (
            .clk   (clk),
            .rst_n (rst_n),
            .up    (rows[i]),
            .down  (rows[i+1])
        );
    end

    assign quotient  = rows[`DIV_ROWS].qacc;
    // lsb of the last partial is the drained pending bit, not remainder
    assign remainder = rows[`DIV_ROWS].partial[`DIV_DIVISOR_W:1];

    // whole pipe flushed by a single reset edge
    a_out_reset: assert property (
        @(posedge clk) !rst_n |=> (quotient == '0 && remainder == '0)
    ) else $error("array_div: outputs not zero after reset");

endmodule

// File: tests/clk_gen.sv
module clk_gen #(
    parameter int half_period  = 10,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic rst_n
);

    int edges = 0;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // count rising edges until reset is over
    always @(posedge clk) begin
        if (edges < reset_cycles) begin
            edges <= edges + 1;
        end
    end

    assign rst_n = (edges >= reset_cycles);  // low over the first reset_cycles edges

endmodule

// File: tests/tb_array_div.sv
`include "div_defs.svh"

module tb_array_div import div_data_pkg::*; #(
    parameter int approx_cols = `DIV_APPROX_COLS
) ();

    localparam int dvd_w  = `DIV_DIVIDEND_W;
    localparam int dvs_w  = `DIV_DIVISOR_W;
    localparam int rows   = `DIV_ROWS;
    localparam int feed_w = dvd_w - dvs_w - 1;  // dividend bits brought down row by row

    localparam int latency       = `DIV_ROWS;
    localparam int n_random      = 400;
    localparam int reset_timeout = 20;
    localparam int drain_timeout = 4 * `DIV_ROWS;

    typedef struct packed {
        int         due;    // edge count after which the result is on the outputs
        quotient_t  q;
        remainder_t r;
    } expect_t;

    logic       clk;
    logic       rst_n;
    dividend_t  dividend = '0;
    divisor_t   divisor  = '0;
    quotient_t  quotient;
    remainder_t remainder;

    dividend_t stim_a [$];
    divisor_t  stim_b [$];
    expect_t   exp_q [$];

    int          cyc        = 0;
    int          drive_idx  = 0;
    bit          drive_done = 1'b0;
    int          n_checked  = 0;
    int          n_exact    = 0;
    logic [31:0] rng_state  = 32'd80404;

    clk_gen #(
        .half_period  (10),
        .reset_cycles (5)
    ) u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    array_div #(
        .approx_cols (approx_cols)
    ) dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .dividend  (dividend),
        .divisor   (divisor),
        .quotient  (quotient),
        .remainder (remainder)
    );

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // bit level model of the restoring array
    function automatic void ref_divide(
        input  dividend_t  a,
        input  divisor_t   b,
        input  int         apx,
        output quotient_t  q,
        output remainder_t r
    );
        logic [dvs_w:0]    part;
        logic [feed_w-1:0] feed;
        logic [dvs_w-1:0]  xs;
        logic [dvs_w-1:0]  ys;
        logic [dvs_w-1:0]  diff;
        logic              bin;
        logic              bout;
        logic              qb;
        part = a[dvd_w-1 -: dvs_w+1];
        feed = a[feed_w-1:0];
        q = '0;
        r = '0;
        for (int row = 0; row < rows; row++) begin
            xs   = part[dvs_w-1:0];
            ys   = b;
            bin  = 1'b0;
            diff = '0;
            // lsb column first, borrow ripples up
            for (int c = 0; c < dvs_w; c++) begin
                bout = (xs[0] != ys[0]) ? ys[0] : bin;
                diff = {(c < apx) ? bout : (xs[0] ^ ys[0] ^ bin), diff[dvs_w-1:1]};
                bin  = bout;
                xs   = xs >> 1;
                ys   = ys >> 1;
            end
            qb = part[dvs_w] | ~bin;
            q  = {q[dvs_w-2:0], qb};
            r  = qb ? diff : part[dvs_w-1:0];  // restore on a failed subtract
            part = {r, feed[feed_w-1]};
            feed = feed << 1;
        end
    endfunction

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_quotient(
        input string     name,
        input quotient_t expected,
        input quotient_t actual
    );
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_remainder(
        input string      name,
        input remainder_t expected,
        input remainder_t actual
    );
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic add_pair(input dividend_t a, input divisor_t b);
        stim_a.push_back(a);
        stim_b.push_back(b);
    endtask

    task automatic build_stimulus();
        dividend_t a;
        divisor_t  b;
        add_pair(16'h0000, 8'h5a);  // zero dividend
        add_pair(16'h0000, 8'h00);
        add_pair(16'h00c7, 8'h01);
        add_pair(16'h3e91, 8'h01);  // overflows
        add_pair(16'hfe01, 8'hff);
        add_pair(16'h1234, 8'hff);
        add_pair(16'hffff, 8'hff);
        add_pair(16'hffff, 8'h9c);
        add_pair(16'hffff, 8'h00);
        add_pair(16'hab17, 8'h00);
        for (int i = 0; i < n_random; i++) begin
            rng_state = xorshift32(rng_state);
            a = rng_state[15:0];
            b = rng_state[23:16];
            // about half the pairs kept clear of overflow
            if (rng_state[24] && b != '0) begin
                a[dvd_w-1 -: dvs_w] = a[dvd_w-1 -: dvs_w] % b;
            end
            add_pair(a, b);
        end
    endtask

    task automatic queue_expectation(input dividend_t a, input divisor_t b, input int due);
        expect_t    e;
        quotient_t  q;
        remainder_t r;
        ref_divide(a, b, approx_cols, q, r);
        // exact cells without overflow give plain integer division
        if (approx_cols == 0 && b != '0 && a[dvd_w-1 -: dvs_w] < b) begin
            check_quotient("ref_divide quotient", quotient_t'(a / dividend_t'(b)), q);
            check_remainder("ref_divide remainder", remainder_t'(a % dividend_t'(b)), r);
            n_exact++;
        end
        e.due = due;
        e.q   = q;
        e.r   = r;
        exp_q.push_back(e);
    endtask

    initial begin
        build_stimulus();
    end

    // one new pair every edge once reset is released
    always @(posedge clk) begin
        if (rst_n && !drive_done) begin
            if (drive_idx < stim_a.size()) begin
                dividend <= stim_a[drive_idx];
                divisor  <= stim_b[drive_idx];
                // cyc still holds the previous edge count, dut captures at the next edge
                queue_expectation(stim_a[drive_idx], stim_b[drive_idx], cyc + 2 + latency);
                drive_idx++;
            end else begin
                drive_done = 1'b1;
            end
        end
    end

    initial begin
        expect_t e;
        int      waited;
        bit      in_reset;

        // outputs read zero after every reset edge
        in_reset = 1'b1;
        waited   = 0;
        while (in_reset) begin
            @(posedge clk);
            in_reset = !rst_n;
            @(negedge clk);
            if (in_reset) begin
                check_quotient("quotient", '0, quotient);
                check_remainder("remainder", '0, remainder);
            end
            waited++;
            if (waited > reset_timeout) begin
                $display("reset was not released within %0d cycles", reset_timeout);
                abort_run();
            end
        end

        waited = 0;
        while (!drive_done || exp_q.size() != 0) begin
            @(negedge clk);
            if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
                e = exp_q.pop_front();
                check_quotient("quotient", e.q, quotient);
                check_remainder("remainder", e.r, remainder);
                n_checked++;
                waited = 0;
            end else if (exp_q.size() != 0 && exp_q[0].due < cyc) begin
                $display("result due after edge %0d was never compared", exp_q[0].due);
                abort_run();
            end else begin
                waited++;
                if (waited > drain_timeout) begin
                    $display("no result arrived for %0d cycles", drain_timeout);
                    abort_run();
                end
            end
        end

        if (n_checked != stim_a.size()) begin
            $display("only %0d of %0d results were compared", n_checked, stim_a.size());
            abort_run();
        end else if (approx_cols == 0 && n_exact == 0) begin
            $display("no pair was compared against integer division");
            abort_run();
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// File: flist.f
+incdir+logic
logic/div_data_pkg.sv
logic/div_pipe_pkg.sv
logic/row_if.sv
logic/sub_row.sv
logic/div_stage.sv
logic/array_div.sv
tests/clk_gen.sv
tests/tb_array_div.sv

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"
mkdir -p build

failed=0
for cols in 0 3; do
    verilator --binary --timing --assert \
        --top-module tb_array_div -Gapprox_cols="$cols" \
        --Mdir "build/obj_cols$cols" -o sim \
        -f flist.f
    log="build/sim_cols$cols.log"
    "./build/obj_cols$cols/sim" > "$log" 2>&1 || true
    cat "$log"
    if grep -q "TEST FAIL" "$log" || ! grep -q "TEST PASS" "$log"; then
        echo "simulation with approx_cols=$cols failed"
        failed=1
    fi
done

exit $failed
